// File: list.f
armPkg.sv
alu.sv
controller.sv
hazardUnit.sv
datapath.sv
armCore.sv
tbClock.sv
armCore_asserts.sv
armCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the armCore testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --assert --timing -f list.f --top-module armCoreTb -o simv \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// File: armCoreTb.sv
`default_nettype none

module armCoreTb import armPkg::*; ();

  logic        clk;
  logic        reset;
  logic [31:0] pc, instr, memAddr, memWriteData, memReadData;
  logic        memWrite;
  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] expAddr [64];
  logic [31:0] expData [64];
  int          expCount;
  int          storeIdx;
  int          progLen;
  logic        storeOk;

  tbClock clkGen (.clk);

  armCore armCore_i (
    .clk, .reset, .pc, .instr, .memAddr, .memWriteData, .memWrite, .memReadData
  );

  // Combinational reads, store at the rising edge
  assign instr       = imem[pc[7:2]];
  assign memReadData = dmem[memAddr[7:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[memAddr[7:2]] <= memWriteData;
    end
  end

  // ====================================================================
  // Instruction encoders
  // ====================================================================
  function automatic logic [31:0] dpOp(input logic [3:0] cond, input logic [3:0] cmd,
                                       input logic s, input logic imm, input logic [3:0] rn,
                                       input logic [3:0] rd, input logic [11:0] op2);
    return {cond, OP_DP, imm, cmd, s, rn, rd, op2};
  endfunction

  function automatic logic [31:0] memOp(input logic [3:0] cond, input logic load,
                                        input logic [3:0] rn, input logic [3:0] rd,
                                        input logic [11:0] off);
    // Pre-indexed, offset added, word, no writeback
    return {cond, OP_MEM, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] brOp(input logic [3:0] cond, input logic [23:0] off);
    return {cond, OP_BR, 2'b10, off};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic loadProgram;
    emit(dpOp(AL, CMD_AND, 1'b0, 1'b1, 4'd0, 4'd0, 12'h000));
    emit(memOp(AL, 1'b1, 4'd0, 4'd1, 12'd0));
    emit(memOp(AL, 1'b1, 4'd0, 4'd2, 12'd4));
    // Load-use on R2
    emit(dpOp(AL, CMD_ADD, 1'b0, 1'b0, 4'd1, 4'd3, 12'h002));
    // Back-to-back forwarding from Memory and Writeback
    emit(dpOp(AL, CMD_SUB, 1'b0, 1'b0, 4'd3, 4'd4, 12'h001));
    emit(dpOp(AL, CMD_AND, 1'b0, 1'b0, 4'd3, 4'd5, 12'h004));
    emit(dpOp(AL, CMD_ORR, 1'b0, 1'b1, 4'd5, 4'd6, {4'd4, 8'hff}));
    emit(dpOp(AL, CMD_ADD, 1'b0, 1'b1, 4'd6, 4'd7, {4'd15, 8'h2b}));
    emit(memOp(AL, 1'b1, 4'd0, 4'd8, 12'd8));
    emit(memOp(AL, 1'b1, 4'd0, 4'd9, 12'd12));
    emit(memOp(AL, 1'b0, 4'd0, 4'd3, 12'd64));
    emit(memOp(AL, 1'b0, 4'd0, 4'd4, 12'd68));
    emit(memOp(AL, 1'b0, 4'd0, 4'd5, 12'd72));
    emit(memOp(AL, 1'b0, 4'd0, 4'd6, 12'd76));
    emit(memOp(AL, 1'b0, 4'd0, 4'd7, 12'd80));
    // Flags and conditional execution
    emit(dpOp(AL, CMD_ORR, 1'b0, 1'b1, 4'd0, 4'd11, 12'h011));
    emit(dpOp(AL, CMD_ORR, 1'b0, 1'b1, 4'd0, 4'd12, 12'h022));
    emit(dpOp(AL, CMD_SUB, 1'b1, 1'b0, 4'd8, 4'd10, 12'h009));
    emit(dpOp(GE, CMD_ADD, 1'b0, 1'b0, 4'd8, 4'd11, 12'h009));
    emit(dpOp(LT, CMD_ADD, 1'b0, 1'b0, 4'd8, 4'd12, 12'h009));
    emit(memOp(AL, 1'b0, 4'd0, 4'd11, 12'd84));
    emit(memOp(AL, 1'b0, 4'd0, 4'd12, 12'd88));
    emit(memOp(EQ, 1'b0, 4'd0, 4'd10, 12'd92));
    emit(memOp(NE, 1'b0, 4'd0, 4'd10, 12'd96));
    // Z and C set for the branches
    emit(dpOp(AL, CMD_SUB, 1'b1, 1'b0, 4'd0, 4'd14, 12'h000));
    emit(brOp(EQ, 24'h000001));
    emit(memOp(AL, 1'b0, 4'd0, 4'd1, 12'd100));
    emit(memOp(AL, 1'b0, 4'd0, 4'd2, 12'd104));
    emit(memOp(AL, 1'b0, 4'd0, 4'd3, 12'd108));
    emit(brOp(NE, 24'h000001));
    emit(memOp(AL, 1'b0, 4'd0, 4'd4, 12'd112));
    emit(memOp(AL, 1'b0, 4'd0, 4'd5, 12'd116));
    // Halt loop
    emit(brOp(AL, 24'hfffffe));
  endtask

  // ====================================================================
  // Reference model, one instruction at a time
  // ====================================================================
  function automatic logic condPass(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n, z, c, v;
    {n, z, c, v} = nzcv;
    case (cond)
      EQ: return z;
      NE: return !z;
      CS: return c;
      CC: return !c;
      MI: return n;
      PL: return !n;
      VS: return v;
      VC: return !v;
      HI: return c && !z;
      LS: return !c || z;
      GE: return n == v;
      LT: return n != v;
      GT: return !z && (n == v);
      LE: return z || (n != v);
      AL: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic buildExpected;
    logic [31:0] regs [16];
    logic [31:0] pcRef, word, a, b, res, imm8;
    logic [32:0] wide;
    logic [3:0]  nzcv, rn, rd;
    logic        taken, c, v;
    int          sh;
    pcRef    = 32'h0;
    nzcv     = 4'h0;
    expCount = 0;
    for (int step = 0; step < 200; step++) begin
      word  = imem[pcRef[7:2]];
      rn    = word[19:16];
      rd    = word[15:12];
      a     = (rn == 4'hf) ? pcRef + 32'd8 : regs[rn];
      taken = condPass(word[31:28], nzcv);
      if (word[27:26] == OP_BR) begin
        if (taken && word == brOp(AL, 24'hfffffe)) begin
          break;
        end
        pcRef = taken ? pcRef + 32'd8 + {{6{word[23]}}, word[23:0], 2'b00} : pcRef + 32'd4;
      end else begin
        if (word[27:26] == OP_MEM && taken) begin
          if (word[20]) begin
            regs[rd] = dmem[(a + {20'h0, word[11:0]}) >> 2];
          end else begin
            expAddr[expCount] = a + {20'h0, word[11:0]};
            expData[expCount] = regs[rd];
            expCount++;
          end
        end else if (word[27:26] == OP_DP && taken) begin
          sh   = 2 * int'(word[11:8]);
          imm8 = {24'h0, word[7:0]};
          if (word[25]) begin
            b = (imm8 >> sh) | (imm8 << (32 - sh));
          end else begin
            b = (word[3:0] == 4'hf) ? pcRef + 32'd8 : regs[word[3:0]];
          end
          c = 1'b0;
          v = 1'b0;
          case (word[24:21])
            CMD_ADD: begin
              wide = {1'b0, a} + {1'b0, b};
              res  = wide[31:0];
              c    = wide[32];
              v    = (a[31] == b[31]) && (res[31] != a[31]);
            end
            CMD_SUB: begin
              res = a - b;
              c   = (a >= b);
              v   = (a[31] != b[31]) && (res[31] != a[31]);
            end
            CMD_AND: res = a & b;
            default: res = a | b;
          endcase
          regs[rd] = res;
          if (word[20]) begin
            nzcv = {res[31], res == 32'h0, c, v};
          end
        end
        pcRef = pcRef + 32'd4;
      end
    end
  endtask

  // ====================================================================
  // Store checker, sampled mid-cycle
  // ====================================================================
  always @(negedge clk) begin
    if (!reset && memWrite) begin
      storeOk = (storeIdx < expCount) && (memAddr == expAddr[storeIdx]) &&
                (memWriteData == expData[storeIdx]);
      assert (storeOk) begin
        storeIdx = storeIdx + 1;
      end else begin
        $display("** Error at %0t: store %0d got addr %h data %h, expected addr %h data %h",
                 $time, storeIdx, memAddr, memWriteData,
                 expAddr[storeIdx], expData[storeIdx]);
        $display("TESTS FAILED");
        $fatal(1, "store mismatch");
      end
    end
  end

  // Four cycles per instruction covers stalls and flushes, plus margin
  initial begin
    #1;
    #((progLen * 4 + 40 + 5) * 8);
    $display("Watchdog expired before the final store, %0d of %0d seen", storeIdx, expCount);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    reset    = 1'b1;
    storeIdx = 0;
    progLen  = 0;
    void'($urandom(32'hb183_abd6));
    for (int i = 0; i < 64; i++) begin
      imem[i] = NOP;
      dmem[i] = (i < 8) ? $urandom : (32'hc0de_0000 ^ (i * 32'h0001_0101));
    end
    loadProgram();
    buildExpected();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    wait (storeIdx == expCount);
    // Room for any stray store after the last one
    repeat (10) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: armCore_asserts.sv
`default_nettype none

module armCoreAsserts (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic [31:0] pc,
  input wire logic        memWrite,
  input wire logic        stallD,
  input wire logic        flushD,
  input wire logic        flushE,
  input wire logic        pcSrcE
);

  // ====================================================================
  // Load-use bubble
  // ====================================================================
  // Stall and Execute flush drop together after one cycle
  assert property (@(posedge clk) disable iff (reset) stallD |=> !stallD && !flushE)
    else $error("load-use stall or flush held longer than one cycle");

  // ====================================================================
  // Branch flush and reset
  // ====================================================================
  // Squashed slot behind a taken branch cannot branch again
  assert property (@(posedge clk) disable iff (reset) flushD |=> !pcSrcE)
    else $error("instruction behind a taken branch was not squashed");

  // No store and pc at zero during reset or right after it
  assert property (@(posedge clk) reset |=> !memWrite && (pc == 32'h0))
    else $error("memWrite or pc wrong during or just after reset");

endmodule

bind armCore armCoreAsserts armCoreAsserts_i (.*);

`default_nettype wire

// File: tbClock.sv
`default_nettype none

module tbClock (
  output logic clk
);

  // Period of 8
  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: armCore.sv
`default_nettype none

module armCore import armPkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output logic [31:0] memAddr,
  output logic [31:0] memWriteData,
  output logic        memWrite,
  input  logic [31:0] memReadData
);

  instrWord   instrD;
  flagsT      aluFlags;
  ctrlT       ctrlE, ctrlM, ctrlW;
  logic       pcSrcE;
  fwdSel      forwardAE, forwardBE;
  logic       stallF, stallD, flushD, flushE;
  logic [3:0] ra1D, ra2D, ra1E, ra2E, waE, waM, waW;

  // Store strobe from the Memory stage
  assign memWrite = ctrlM.memWrite;

  controller controller_i (
    .clk, .reset, .instrD, .aluFlags, .stallD, .flushE,
    .ctrlE, .ctrlM, .ctrlW, .pcSrcE
  );

  datapath datapath_i (
    .clk, .reset, .ctrlE, .ctrlM, .ctrlW, .pcSrcE,
    .stallF, .stallD, .flushD, .flushE, .forwardAE, .forwardBE,
    .pc, .instr, .instrD, .aluFlags,
    .memAddr, .memWriteData, .memReadData,
    .ra1D, .ra2D, .ra1E, .ra2E, .waE, .waM, .waW
  );

  // Control bits taken straight from the carried structs
  hazardUnit hazardUnit_i (
    .ra1D, .ra2D, .ra1E, .ra2E, .waE, .waM, .waW,
    .regWriteM (ctrlM.regWrite),
    .regWriteW (ctrlW.regWrite),
    .memToRegE (ctrlE.memToReg),
    .pcSrcE,
    .forwardAE, .forwardBE, .stallF, .stallD, .flushD, .flushE
  );

endmodule

`default_nettype wire

// File: datapath.sv
`default_nettype none

module datapath import armPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  ctrlT        ctrlE,
  input  ctrlT        ctrlM,
  input  ctrlT        ctrlW,
  input  logic        pcSrcE,
  input  logic        stallF,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        flushE,
  input  fwdSel       forwardAE,
  input  fwdSel       forwardBE,
  output logic [31:0] pc,
  input  logic [31:0] instr,
  output instrWord    instrD,
  output flagsT       aluFlags,
  output logic [31:0] memAddr,
  output logic [31:0] memWriteData,
  input  logic [31:0] memReadData,
  output logic [3:0]  ra1D,
  output logic [3:0]  ra2D,
  output logic [3:0]  ra1E,
  output logic [3:0]  ra2E,
  output logic [3:0]  waE,
  output logic [3:0]  waM,
  output logic [3:0]  waW
);

  logic [31:0] pcPlus4, pcNext;
  logic [31:0] regFile [16];
  logic [31:0] rd1D, rd2D, extImmD;
  logic [3:0]  waD;
  logic [23:0] imm24D;
  logic        isMemD, isBranchD;
  logic [31:0] rd1E, rd2E, extImmE;
  logic [31:0] srcAE, srcBE, writeDataE, aluResultE;
  logic [31:0] aluOutM, writeDataM;
  logic [31:0] aluOutW, readDataW, resultW;

  // Rotate imm8 right by twice the rot field
  function automatic logic [31:0] rotImm(input logic [3:0] rot, input logic [7:0] imm8);
    logic [63:0] dbl;
    dbl    = {2{24'h0, imm8}} >> {rot, 1'b0};
    rotImm = dbl[31:0];
  endfunction

  // Operand bypass mux
  function automatic logic [31:0] bypass(input fwdSel sel, input logic [31:0] regVal);
    case (sel)
      FROM_M:  bypass = aluOutM;
      FROM_W:  bypass = resultW;
      default: bypass = regVal;
    endcase
  endfunction

  // ====================================================================
  // Fetch
  // ====================================================================
  assign pcPlus4 = pc + 32'd4;
  assign pcNext  = pcSrcE ? aluResultE : pcPlus4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= 32'h0;
    end else if (!stallF) begin
      pc <= pcNext;
    end
  end

  // ====================================================================
  // Decode
  // ====================================================================
  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      instrD <= NOP;
    end else if (!stallD) begin
      instrD <= instr;
    end
  end

  assign isMemD    = (instrD.dp.op == OP_MEM);
  assign isBranchD = (instrD.dp.op == OP_BR);

  // Branches read R15, stores read Rd as data
  assign ra1D = isBranchD ? 4'hf : instrD.dp.rn;
  assign ra2D = isMemD ? instrD.mem.rd : instrD.dp.imm8[3:0];
  assign waD  = instrD.dp.rd;

  // Written mid-cycle so Decode sees the Writeback value
  always_ff @(negedge clk) begin
    if (ctrlW.regWrite) begin
      regFile[waW] <= resultW;
    end
  end

  // pc already points two words past Decode
  assign rd1D = (ra1D == 4'hf) ? pcPlus4 : regFile[ra1D];
  assign rd2D = (ra2D == 4'hf) ? pcPlus4 : regFile[ra2D];

  // Immediate by instruction class
  assign imm24D = {instrD.mem.rn, instrD.mem.rd, instrD.mem.imm12};
  always_comb begin
    case (instrD.dp.op)
      OP_MEM:  extImmD = {20'h0, instrD.mem.imm12};
      OP_BR:   extImmD = {{6{imm24D[23]}}, imm24D, 2'b00};
      default: extImmD = rotImm(instrD.dp.rot, instrD.dp.imm8);
    endcase
  end

  // ====================================================================
  // Execute
  // ====================================================================
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
  end

  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      ra1E <= 4'h0;
      ra2E <= 4'h0;
      waE  <= 4'h0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      waE  <= waD;
    end
  end

  assign srcAE      = bypass(forwardAE, rd1E);
  assign writeDataE = bypass(forwardBE, rd2E);
  assign srcBE      = ctrlE.aluSrc ? extImmE : writeDataE;

  alu aluE (
    .a      (srcAE),
    .b      (srcBE),
    .op     (ctrlE.aluCtrl),
    .result (aluResultE),
    .flags  (aluFlags)
  );

  // ====================================================================
  // Memory
  // ====================================================================
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    waM        <= waE;
  end

  assign memAddr      = aluOutM;
  assign memWriteData = writeDataM;

  // ====================================================================
  // Writeback
  // ====================================================================
  always_ff @(posedge clk) begin
    aluOutW <= aluOutM;
    waW     <= waM;
    // Load data captured only for loads
    if (ctrlM.memToReg) begin
      readDataW <= memReadData;
    end
  end

  assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

endmodule

`default_nettype wire

// File: hazardUnit.sv
`default_nettype none

module hazardUnit import armPkg::*; (
  input  logic [3:0] ra1D,
  input  logic [3:0] ra2D,
  input  logic [3:0] ra1E,
  input  logic [3:0] ra2E,
  input  logic [3:0] waE,
  input  logic [3:0] waM,
  input  logic [3:0] waW,
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       memToRegE,
  input  logic       pcSrcE,
  output fwdSel      forwardAE,
  output fwdSel      forwardBE,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);

  logic ldStall;

  // Memory result is newer, so it wins over Writeback
  function automatic fwdSel pickSource(input logic [3:0] ra);
    if (regWriteM && (waM == ra)) begin
      pickSource = FROM_M;
    end else if (regWriteW && (waW == ra)) begin
      pickSource = FROM_W;
    end else begin
      pickSource = REGFILE;
    end
  endfunction

  assign forwardAE = pickSource(ra1E);
  assign forwardBE = pickSource(ra2E);

  // Load in Execute feeding the instruction in Decode
  assign ldStall = memToRegE && ((waE == ra1D) || (waE == ra2D));

  assign stallF = ldStall;
  assign stallD = ldStall;
  // Taken branch kills the two younger instructions
  assign flushD = pcSrcE;
  assign flushE = ldStall | pcSrcE;

endmodule

`default_nettype wire

// File: controller.sv
`default_nettype none

module controller import armPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  instrWord instrD,
  input  flagsT    aluFlags,
  input  logic     stallD,
  input  logic     flushE,
  output ctrlT     ctrlE,
  output ctrlT     ctrlM,
  output ctrlT     ctrlW,
  output logic     pcSrcE
);

  ctrlT  ctrlD;
  ctrlT  ctrlGatedE;
  flagsT flags;
  logic  condExE;

  // Condition field against stored NZCV
  function automatic logic condHolds(input logic [3:0] cond, input flagsT f);
    case (cond)
      EQ:      condHolds = f.z;
      NE:      condHolds = ~f.z;
      CS:      condHolds = f.c;
      CC:      condHolds = ~f.c;
      MI:      condHolds = f.n;
      PL:      condHolds = ~f.n;
      VS:      condHolds = f.v;
      VC:      condHolds = ~f.v;
      HI:      condHolds = f.c & ~f.z;
      LS:      condHolds = ~f.c | f.z;
      GE:      condHolds = (f.n == f.v);
      LT:      condHolds = (f.n != f.v);
      GT:      condHolds = ~f.z & (f.n == f.v);
      LE:      condHolds = f.z | (f.n != f.v);
      AL:      condHolds = 1'b1;
      default: condHolds = 1'b0;
    endcase
  endfunction

  // ====================================================================
  // Decode
  // ====================================================================
  always_comb begin
    ctrlD      = '0;
    ctrlD.cond = instrD.dp.cond;
    // NV words decode to a bubble
    if (instrD.dp.cond != NV) begin
      case (instrD.dp.op)
        OP_DP: begin
          ctrlD.regWrite  = 1'b1;
          ctrlD.aluSrc    = instrD.dp.immFlag;
          ctrlD.flagWrite = instrD.dp.sBit;
          case (instrD.dp.cmd)
            CMD_SUB: ctrlD.aluCtrl = SUB;
            CMD_AND: ctrlD.aluCtrl = AND;
            CMD_ORR: ctrlD.aluCtrl = ORR;
            default: ctrlD.aluCtrl = ADD;
          endcase
        end
        OP_MEM: begin
          // Address is Rn plus imm12
          ctrlD.regWrite = instrD.mem.l;
          ctrlD.memWrite = ~instrD.mem.l;
          ctrlD.memToReg = instrD.mem.l;
          ctrlD.aluSrc   = 1'b1;
          ctrlD.aluCtrl  = ADD;
          ctrlD.regSrc   = 1'b1;
        end
        OP_BR: begin
          // Target is R15 plus offset
          ctrlD.branch  = 1'b1;
          ctrlD.aluSrc  = 1'b1;
          ctrlD.aluCtrl = ADD;
        end
        default: ctrlD = '0;
      endcase
    end
  end

  // ====================================================================
  // Execute
  // ====================================================================
  // Stalled Decode sends a bubble down
  always_ff @(posedge clk) begin
    if (reset || flushE || stallD) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
    end
  end

  assign condExE = condHolds(ctrlE.cond, flags);

  // Side effects only when the condition passes
  always_comb begin
    ctrlGatedE           = ctrlE;
    ctrlGatedE.regWrite  = ctrlE.regWrite & condExE;
    ctrlGatedE.memWrite  = ctrlE.memWrite & condExE;
    ctrlGatedE.flagWrite = ctrlE.flagWrite & condExE;
    ctrlGatedE.branch    = ctrlE.branch & condExE;
  end

  assign pcSrcE = ctrlGatedE.branch;

  // Flags visible to the next instruction in Execute
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (ctrlGatedE.flagWrite) begin
      flags <= aluFlags;
    end
  end

  // ====================================================================
  // Memory and Writeback
  // ====================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= ctrlGatedE;
      ctrlW <= ctrlM;
    end
  end

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none

module alu import armPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOp        op,
  output logic [31:0] result,
  output flagsT       flags
);

  logic [31:0] bMod;
  logic [32:0] sum;
  logic        isSub;
  logic        isArith;

  assign isSub   = (op == SUB);
  assign isArith = (op == ADD) || isSub;

  // Subtract as a plus inverted b plus one
  assign bMod = isSub ? ~b : b;
  assign sum  = {1'b0, a} + {1'b0, bMod} + {32'h0, isSub};

  always_comb begin
    case (op)
      AND:     result = a & b;
      ORR:     result = a | b;
      default: result = sum[31:0];
    endcase
  end

  // N and Z for every op
  assign flags.n = result[31];
  assign flags.z = (result == 32'h0);
  // Carry out, which for SUB means no borrow
  assign flags.c = isArith & sum[32];
  // Overflow when same-sign inputs give a result of the other sign
  assign flags.v = isArith & (a[31] == bMod[31]) & (sum[31] != a[31]);

endmodule

`default_nettype wire

// File: armPkg.sv
`default_nettype none

package armPkg;

  // ====================================================================
  // Instruction encodings
  // ====================================================================

  // Op field values, bits 27:26
  localparam logic [1:0] OP_DP  = 2'b00;
  localparam logic [1:0] OP_MEM = 2'b01;
  localparam logic [1:0] OP_BR  = 2'b10;

  // Data processing cmd field
  localparam logic [3:0] CMD_AND = 4'b0000;
  localparam logic [3:0] CMD_SUB = 4'b0010;
  localparam logic [3:0] CMD_ADD = 4'b0100;
  localparam logic [3:0] CMD_ORR = 4'b1100;

  // Condition codes
  localparam logic [3:0] EQ = 4'h0;
  localparam logic [3:0] NE = 4'h1;
  localparam logic [3:0] CS = 4'h2;
  localparam logic [3:0] CC = 4'h3;
  localparam logic [3:0] MI = 4'h4;
  localparam logic [3:0] PL = 4'h5;
  localparam logic [3:0] VS = 4'h6;
  localparam logic [3:0] VC = 4'h7;
  localparam logic [3:0] HI = 4'h8;
  localparam logic [3:0] LS = 4'h9;
  localparam logic [3:0] GE = 4'ha;
  localparam logic [3:0] LT = 4'hb;
  localparam logic [3:0] GT = 4'hc;
  localparam logic [3:0] LE = 4'hd;
  localparam logic [3:0] AL = 4'he;
  // Never executes, used for pipeline bubbles
  localparam logic [3:0] NV = 4'hf;

  // Bubble loaded into Decode on reset and flush
  localparam logic [31:0] NOP = 32'hf000_0000;

  // Data processing view
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic       immFlag;
    logic [3:0] cmd;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rot;
    logic [7:0] imm8;   // Rm sits in the low nibble
  } dpFields;

  // Load/store view
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        immFlag;
    logic        p, u, b, w, l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } memFields;

  typedef union packed {
    dpFields  dp;
    memFields mem;
  } instrWord;

  // ====================================================================
  // Pipeline types
  // ====================================================================

  typedef enum logic [1:0] {ADD, SUB, AND, ORR} aluOp;

  typedef struct packed {
    logic n, z, c, v;
  } flagsT;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       branch;
    logic       aluSrc;
    aluOp       aluCtrl;
    logic       flagWrite;
    logic       regSrc;     // Second read port takes Rd
    logic [3:0] cond;
  } ctrlT;

  typedef enum logic [1:0] {REGFILE, FROM_W, FROM_M} fwdSel;

endpackage

`default_nettype wire
